// File: int_core.f
+incdir+tb
logic/rv_pkg.sv
logic/decode_riscv.sv
logic/int_regfile.sv
logic/int_execute.sv
logic/int_result.sv
logic/int_core.sv
tb/tb_int_core.sv

// File: logic/decode_riscv.sv
module decode_riscv(
	input logic mode64,
	input logic [31:0] insn,
	input logic [rv_pkg::xlen-1:0] pc,
	input logic insn_pred,
	output rv_pkg::uop_op_t op,
	output logic [rv_pkg::lg_arch_regs-1:0] src_a,
	output logic [rv_pkg::lg_arch_regs-1:0] src_b,
	output logic [rv_pkg::lg_arch_regs-1:0] dst,
	output logic src_a_valid,
	output logic src_b_valid,
	output logic dst_valid,
	output logic [rv_pkg::xlen-1:0] rvimm,
	output logic is_br,
	output logic br_pred,
	output logic is_cheap_int,
	output logic unsupported
);

	wire [6:0] opcode = insn[6:0];
	wire [2:0] funct3 = insn[14:12];
	wire [6:0] funct7 = insn[31:25];
	wire [rv_pkg::lg_arch_regs-1:0] rd = insn[11:7];
	wire [rv_pkg::lg_arch_regs-1:0] rs1 = insn[19:15];
	wire [rv_pkg::lg_arch_regs-1:0] rs2 = insn[24:20];
	wire rd_nz = (rd != '0);
	wire rs1_is_link = (rs1 == 5'd1) || (rs1 == 5'd5); // ra or t0
	wire [rv_pkg::xlen-1:0] i_imm = {{(rv_pkg::xlen-12){insn[31]}}, insn[31:20]};
	wire [rv_pkg::xlen-1:0] s_imm = {{(rv_pkg::xlen-12){insn[31]}}, insn[31:25], insn[11:7]};
	wire [rv_pkg::xlen-1:0] u_imm = {{(rv_pkg::xlen-32){insn[31]}}, insn[31:12], 12'd0};

	logic [rv_pkg::xlen-1:0] pc_off;
	logic nop_if_x0; // op collapses to NOP when rd is x0

	always_comb
	begin
		case (opcode)
			rv_pkg::op_auipc: pc_off = u_imm;
			rv_pkg::op_branch:
				pc_off = {{(rv_pkg::xlen-12){insn[31]}}, insn[7], insn[30:25], insn[11:8], 1'b0};
			rv_pkg::op_jal:
				pc_off = {{(rv_pkg::xlen-20){insn[31]}}, insn[19:12], insn[20], insn[30:21], 1'b0};
			default: pc_off = '0;
		endcase
	end

	wire [rv_pkg::xlen-1:0] pc_sum = pc + pc_off;
	wire [rv_pkg::xlen-1:0] pc_rel = mode64 ? pc_sum :
		{{(rv_pkg::xlen-32){pc_sum[31]}}, pc_sum[31:0]}; // 32-bit address space

	always_comb
	begin
		op = rv_pkg::II;
		src_a = rs1;
		src_b = rs2;
		dst = rd;
		src_a_valid = 1'b0;
		src_b_valid = 1'b0;
		dst_valid = 1'b0;
		rvimm = '0;
		is_br = 1'b0;
		br_pred = 1'b0;
		is_cheap_int = 1'b0;
		unsupported = 1'b0;
		nop_if_x0 = 1'b0;
		case (opcode)
			rv_pkg::op_load:
			begin
				src_a_valid = 1'b1;
				dst_valid = rd_nz;
				rvimm = i_imm;
				unsupported = 1'b1;
				case (funct3)
					3'd0: op = rv_pkg::LB;
					3'd1: op = rv_pkg::LH;
					3'd2: op = rv_pkg::LW;
					3'd3: op = rv_pkg::LD;
					3'd4: op = rv_pkg::LBU;
					3'd5: op = rv_pkg::LHU;
					default: op = rv_pkg::II;
				endcase
			end
			rv_pkg::op_misc_mem:
			begin
				op = rv_pkg::NOP;
				unsupported = 1'b1;
			end
			rv_pkg::op_imm:
			begin
				src_a_valid = 1'b1;
				dst_valid = rd_nz;
				rvimm = i_imm;
				is_cheap_int = 1'b1;
				nop_if_x0 = 1'b1;
				case (funct3)
					3'd0: op = rv_pkg::ADDI;
					3'd1: op = (insn[31:26] == 6'h00) ? rv_pkg::SLLI : rv_pkg::II;
					3'd2: op = rv_pkg::SLTI;
					3'd3: op = rv_pkg::SLTIU;
					3'd4: op = rv_pkg::XORI;
					3'd5:
					begin
						if (insn[31:26] == 6'h00)
							op = rv_pkg::SRLI;
						else if (insn[31:26] == 6'h10)
							op = rv_pkg::SRAI;
					end
					3'd6: op = rv_pkg::ORI;
					default: op = rv_pkg::ANDI;
				endcase
			end
			rv_pkg::op_auipc, rv_pkg::op_lui:
			begin
				op = (opcode == rv_pkg::op_lui) ? rv_pkg::LUI : rv_pkg::AUIPC;
				dst_valid = rd_nz;
				rvimm = (opcode == rv_pkg::op_lui) ? u_imm : pc_rel;
				is_cheap_int = 1'b1;
				nop_if_x0 = 1'b1;
			end
			rv_pkg::op_imm32:
			begin
				src_a_valid = 1'b1;
				dst_valid = rd_nz;
				rvimm = i_imm;
				is_cheap_int = 1'b1;
				nop_if_x0 = 1'b1;
				if (funct3 == 3'd0)
					op = rv_pkg::ADDIW;
			end
			rv_pkg::op_store:
			begin
				src_a_valid = 1'b1;
				src_b_valid = 1'b1;
				rvimm = s_imm;
				unsupported = 1'b1;
				case (funct3)
					3'd0: op = rv_pkg::SB;
					3'd1: op = rv_pkg::SH;
					3'd2: op = rv_pkg::SW;
					3'd3: op = rv_pkg::SD;
					default: op = rv_pkg::II;
				endcase
			end
			rv_pkg::op_reg:
			begin
				src_a_valid = 1'b1;
				src_b_valid = 1'b1;
				dst_valid = rd_nz && (funct7 != 7'h01);
				is_cheap_int = (funct7 != 7'h01);
				unsupported = (funct7 == 7'h01); // M extension
				nop_if_x0 = 1'b1;
				case ({funct7, funct3})
					{7'h00, 3'd0}: op = rv_pkg::ADDU;
					{7'h20, 3'd0}: op = rv_pkg::SUBU;
					{7'h00, 3'd1}: op = rv_pkg::SLL;
					{7'h00, 3'd2}: op = rv_pkg::SLT;
					{7'h00, 3'd3}: op = rv_pkg::SLTU;
					{7'h00, 3'd4}: op = rv_pkg::XOR;
					{7'h00, 3'd5}: op = rv_pkg::SRL;
					{7'h20, 3'd5}: op = rv_pkg::SRA;
					{7'h00, 3'd6}: op = rv_pkg::OR;
					{7'h00, 3'd7}: op = rv_pkg::AND;
					{7'h01, 3'd0}: op = rv_pkg::MUL;
					{7'h01, 3'd1}: op = rv_pkg::MULH;
					{7'h01, 3'd3}: op = rv_pkg::MULHU;
					{7'h01, 3'd4}: op = rv_pkg::DIV;
					{7'h01, 3'd5}: op = rv_pkg::DIVU;
					{7'h01, 3'd6}: op = rv_pkg::REM;
					{7'h01, 3'd7}: op = rv_pkg::REMU;
					default: op = rv_pkg::II;
				endcase
			end
			rv_pkg::op_branch:
			begin
				src_a_valid = 1'b1;
				src_b_valid = 1'b1;
				rvimm = pc_rel;
				is_br = 1'b1;
				br_pred = insn_pred;
				is_cheap_int = 1'b1;
				case (funct3)
					3'd0: op = rv_pkg::BEQ;
					3'd1: op = rv_pkg::BNE;
					3'd4: op = rv_pkg::BLT;
					3'd5: op = rv_pkg::BGE;
					3'd6: op = rv_pkg::BLTU;
					3'd7: op = rv_pkg::BGEU;
					default: op = rv_pkg::II;
				endcase
			end
			rv_pkg::op_jalr:
			begin
				src_a_valid = 1'b1;
				dst_valid = rd_nz;
				rvimm = i_imm;
				is_br = 1'b1;
				br_pred = 1'b1;
				is_cheap_int = 1'b1;
				if (rd_nz)
					op = rv_pkg::JALR;
				else
					op = rs1_is_link ? rv_pkg::RET : rv_pkg::JR;
			end
			rv_pkg::op_jal:
			begin
				dst_valid = rd_nz;
				rvimm = pc_rel;
				is_br = 1'b1;
				br_pred = 1'b1;
				is_cheap_int = 1'b1;
				op = rd_nz ? rv_pkg::JAL : rv_pkg::J;
			end
			rv_pkg::op_system:
			begin
				if (insn[31:7] == '0)
				begin
					op = rv_pkg::BREAK;
					unsupported = 1'b1;
				end
				else if (insn[31:20] == 12'd1 && insn[19:7] == '0)
				begin
					op = rv_pkg::MONITOR;
					unsupported = 1'b1;
				end
				else if (funct3 == 3'd2 && insn[31:20] == rv_pkg::csr_cycle)
					op = rv_pkg::RDCYCLE;
				else if (funct3 == 3'd2 && insn[31:20] == rv_pkg::csr_instret)
					op = rv_pkg::RDINSTRET;
				dst_valid = rd_nz && (op == rv_pkg::RDCYCLE || op == rv_pkg::RDINSTRET);
				nop_if_x0 = (op == rv_pkg::RDCYCLE || op == rv_pkg::RDINSTRET);
			end
			default: op = rv_pkg::II;
		endcase
		if (nop_if_x0 && !rd_nz && op != rv_pkg::II)
			op = rv_pkg::NOP;
		if (op == rv_pkg::II)
		begin
			// illegal encodings retire as no-ops
			dst_valid = 1'b0;
			is_br = 1'b0;
			br_pred = 1'b0;
			is_cheap_int = 1'b0;
			unsupported = 1'b1;
		end
	end

endmodule

// File: logic/int_core.sv
module int_core(
	input logic clk,
	input logic rst,
	input logic insn_valid,
	input logic [31:0] insn,
	input logic [rv_pkg::xlen-1:0] pc,
	input logic insn_pred,
	input logic mode64,
	output logic rslt_valid,
	output logic [rv_pkg::lg_arch_regs-1:0] rslt_dst,
	output logic [rv_pkg::xlen-1:0] rslt_data,
	output logic rslt_unsupported,
	output logic redirect,
	output logic [rv_pkg::xlen-1:0] redirect_pc
);

	rv_pkg::uop_op_t op, ex_op;
	logic [rv_pkg::lg_arch_regs-1:0] src_a, src_b, dst, ex_dst, wb_dst;
	logic src_a_valid, src_b_valid, dst_valid;
	logic is_br, br_pred, unsupported;
	logic [rv_pkg::xlen-1:0] rvimm, data_a, data_b;
	logic ex_valid, ex_dst_valid, ex_taken, ex_pred, ex_unsupported;
	logic [rv_pkg::xlen-1:0] ex_value, ex_target, ex_pc;
	logic wb_en;
	logic [rv_pkg::xlen-1:0] wb_data, cycle_count, instret_count;

	decode_riscv dec(
		.mode64(mode64), .insn(insn), .pc(pc), .insn_pred(insn_pred),
		.op(op), .src_a(src_a), .src_b(src_b), .dst(dst),
		.src_a_valid(src_a_valid), .src_b_valid(src_b_valid), .dst_valid(dst_valid),
		.rvimm(rvimm), .is_br(is_br), .br_pred(br_pred),
		.is_cheap_int(), // every executed op is single cycle here
		.unsupported(unsupported));

	int_regfile rf(
		.clk(clk), .rst(rst), .rd_a(src_a), .rd_b(src_b),
		.data_a(data_a), .data_b(data_b),
		.wr_en(wb_en), .wr_addr(wb_dst), .wr_data(wb_data));

	int_execute ex(
		.clk(clk), .rst(rst), .insn_valid(insn_valid), .mode64(mode64),
		.op(op), .dst(dst), .dst_valid(dst_valid), .src_a(src_a), .src_b(src_b),
		.src_a_valid(src_a_valid), .src_b_valid(src_b_valid), .rvimm(rvimm),
		.is_br(is_br), .br_pred(br_pred), .unsupported(unsupported), .pc(pc),
		.data_a(data_a), .data_b(data_b),
		.wb_en(wb_en), .wb_dst(wb_dst), .wb_data(wb_data),
		.cycle_count(cycle_count), .instret_count(instret_count),
		.ex_valid(ex_valid), .ex_op(ex_op), .ex_dst(ex_dst), .ex_dst_valid(ex_dst_valid),
		.ex_value(ex_value), .ex_taken(ex_taken), .ex_target(ex_target),
		.ex_pred(ex_pred), .ex_pc(ex_pc), .ex_unsupported(ex_unsupported));

	int_result rs(
		.clk(clk), .rst(rst), .ex_valid(ex_valid), .ex_op(ex_op),
		.ex_dst(ex_dst), .ex_dst_valid(ex_dst_valid), .ex_value(ex_value),
		.ex_taken(ex_taken), .ex_target(ex_target), .ex_pred(ex_pred),
		.ex_pc(ex_pc), .ex_unsupported(ex_unsupported),
		.wb_en(wb_en), .wb_dst(wb_dst), .wb_data(wb_data),
		.cycle_count(cycle_count), .instret_count(instret_count),
		.rslt_valid(rslt_valid), .rslt_dst(rslt_dst), .rslt_data(rslt_data),
		.rslt_unsupported(rslt_unsupported),
		.redirect(redirect), .redirect_pc(redirect_pc));

endmodule

// File: logic/int_execute.sv
module int_execute(
	input logic clk,
	input logic rst,
	input logic insn_valid,
	input logic mode64,
	input rv_pkg::uop_op_t op,
	input logic [rv_pkg::lg_arch_regs-1:0] dst,
	input logic dst_valid,
	input logic [rv_pkg::lg_arch_regs-1:0] src_a,
	input logic [rv_pkg::lg_arch_regs-1:0] src_b,
	input logic src_a_valid,
	input logic src_b_valid,
	input logic [rv_pkg::xlen-1:0] rvimm,
	input logic is_br,
	input logic br_pred,
	input logic unsupported,
	input logic [rv_pkg::xlen-1:0] pc,
	input logic [rv_pkg::xlen-1:0] data_a,
	input logic [rv_pkg::xlen-1:0] data_b,
	input logic wb_en,
	input logic [rv_pkg::lg_arch_regs-1:0] wb_dst,
	input logic [rv_pkg::xlen-1:0] wb_data,
	input logic [rv_pkg::xlen-1:0] cycle_count,
	input logic [rv_pkg::xlen-1:0] instret_count,
	output logic ex_valid,
	output rv_pkg::uop_op_t ex_op,
	output logic [rv_pkg::lg_arch_regs-1:0] ex_dst,
	output logic ex_dst_valid,
	output logic [rv_pkg::xlen-1:0] ex_value,
	output logic ex_taken,
	output logic [rv_pkg::xlen-1:0] ex_target,
	output logic ex_pred,
	output logic [rv_pkg::xlen-1:0] ex_pc,
	output logic ex_unsupported
);

	logic [rv_pkg::xlen-1:0] opnd_a, opnd_b;
	logic [rv_pkg::xlen-1:0] alu_out, target;
	logic take, pred;

	// newest producer wins
	function automatic logic [rv_pkg::xlen-1:0] bypass(
		input logic [rv_pkg::lg_arch_regs-1:0] src,
		input logic src_valid,
		input logic [rv_pkg::xlen-1:0] rf_data);
		if (!src_valid)
			return '0;
		else if (ex_valid && ex_dst_valid && ex_dst == src)
			return ex_value;
		else if (wb_en && wb_dst == src)
			return wb_data;
		return rf_data;
	endfunction

	function automatic logic [rv_pkg::xlen-1:0] narrow(
		input logic [rv_pkg::xlen-1:0] v,
		input logic m64);
		return m64 ? v : {{(rv_pkg::xlen-32){v[31]}}, v[31:0]};
	endfunction

	always_comb
	begin
		opnd_a = bypass(src_a, src_a_valid, data_a);
		opnd_b = bypass(src_b, src_b_valid, data_b);
	end

	wire [rv_pkg::xlen-1:0] link = narrow(pc + 64'd4, mode64);
	wire [rv_pkg::xlen-1:0] jalr_sum = opnd_a + rvimm;
	wire [rv_pkg::xlen-1:0] jalr_tgt = narrow({jalr_sum[rv_pkg::xlen-1:1], 1'b0}, mode64);
	wire [31:0] sum_w = opnd_a[31:0] + rvimm[31:0];

	always_comb
	begin
		alu_out = '0;
		take = 1'b0;
		target = rvimm; // pc-relative target from decode
		pred = br_pred;
		case (op)
			rv_pkg::ADDI: alu_out = opnd_a + rvimm;
			rv_pkg::SLLI: alu_out = opnd_a << rvimm[5:0];
			rv_pkg::SLTI: alu_out = {63'd0, $signed(opnd_a) < $signed(rvimm)};
			rv_pkg::SLTIU: alu_out = {63'd0, opnd_a < rvimm};
			rv_pkg::XORI: alu_out = opnd_a ^ rvimm;
			rv_pkg::SRLI: alu_out = opnd_a >> rvimm[5:0];
			rv_pkg::SRAI: alu_out = $signed(opnd_a) >>> rvimm[5:0];
			rv_pkg::ORI: alu_out = opnd_a | rvimm;
			rv_pkg::ANDI: alu_out = opnd_a & rvimm;
			rv_pkg::ADDIW: alu_out = {{32{sum_w[31]}}, sum_w};
			rv_pkg::ADDU: alu_out = opnd_a + opnd_b;
			rv_pkg::SUBU: alu_out = opnd_a - opnd_b;
			rv_pkg::SLL: alu_out = opnd_a << opnd_b[5:0];
			rv_pkg::SLT: alu_out = {63'd0, $signed(opnd_a) < $signed(opnd_b)};
			rv_pkg::SLTU: alu_out = {63'd0, opnd_a < opnd_b};
			rv_pkg::XOR: alu_out = opnd_a ^ opnd_b;
			rv_pkg::SRL: alu_out = opnd_a >> opnd_b[5:0];
			rv_pkg::SRA: alu_out = $signed(opnd_a) >>> opnd_b[5:0];
			rv_pkg::OR: alu_out = opnd_a | opnd_b;
			rv_pkg::AND: alu_out = opnd_a & opnd_b;
			rv_pkg::LUI, rv_pkg::AUIPC: alu_out = rvimm;
			rv_pkg::BEQ: take = (opnd_a == opnd_b);
			rv_pkg::BNE: take = (opnd_a != opnd_b);
			rv_pkg::BLT: take = ($signed(opnd_a) < $signed(opnd_b));
			rv_pkg::BGE: take = ($signed(opnd_a) >= $signed(opnd_b));
			rv_pkg::BLTU: take = (opnd_a < opnd_b);
			rv_pkg::BGEU: take = (opnd_a >= opnd_b);
			rv_pkg::JAL, rv_pkg::J:
			begin
				alu_out = link;
				take = 1'b1;
			end
			rv_pkg::JALR, rv_pkg::JR, rv_pkg::RET:
			begin
				alu_out = link;
				take = 1'b1;
				target = jalr_tgt;
				// no target predictor, fetch only got it right on fall-through
				pred = br_pred && (jalr_tgt == link);
			end
			rv_pkg::RDCYCLE: alu_out = cycle_count;
			rv_pkg::RDINSTRET: alu_out = instret_count + {63'd0, ex_valid}; // older one retires now
			default: alu_out = '0;
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (rst)
			ex_valid <= 1'b0;
		else
			ex_valid <= insn_valid;
		if (insn_valid)
		begin
			ex_op <= op;
			ex_dst <= dst;
			ex_dst_valid <= dst_valid && !unsupported;
			ex_value <= alu_out;
			ex_taken <= is_br && take;
			ex_target <= target;
			ex_pred <= pred;
			ex_pc <= pc;
			ex_unsupported <= unsupported;
		end
	end

endmodule

// File: logic/int_regfile.sv
module int_regfile(
	input logic clk,
	input logic rst,
	input logic [rv_pkg::lg_arch_regs-1:0] rd_a,
	input logic [rv_pkg::lg_arch_regs-1:0] rd_b,
	output logic [rv_pkg::xlen-1:0] data_a,
	output logic [rv_pkg::xlen-1:0] data_b,
	input logic wr_en,
	input logic [rv_pkg::lg_arch_regs-1:0] wr_addr,
	input logic [rv_pkg::xlen-1:0] wr_data
);

	logic [rv_pkg::xlen-1:0] regs [1:31]; // no storage behind x0

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			for (int i = 1; i < 32; i++)
				regs[i] <= '0;
		end
		else if (wr_en && wr_addr != '0)
		begin
			regs[wr_addr] <= wr_data;
		end
	end

	assign data_a = (rd_a == '0) ? '0 : regs[rd_a];
	assign data_b = (rd_b == '0) ? '0 : regs[rd_b];

endmodule

// File: logic/int_result.sv
module int_result(
	input logic clk,
	input logic rst,
	input logic ex_valid,
	input rv_pkg::uop_op_t ex_op,
	input logic [rv_pkg::lg_arch_regs-1:0] ex_dst,
	input logic ex_dst_valid,
	input logic [rv_pkg::xlen-1:0] ex_value,
	input logic ex_taken,
	input logic [rv_pkg::xlen-1:0] ex_target,
	input logic ex_pred,
	input logic [rv_pkg::xlen-1:0] ex_pc,
	input logic ex_unsupported,
	output logic wb_en,
	output logic [rv_pkg::lg_arch_regs-1:0] wb_dst,
	output logic [rv_pkg::xlen-1:0] wb_data,
	output logic [rv_pkg::xlen-1:0] cycle_count,
	output logic [rv_pkg::xlen-1:0] instret_count,
	output logic rslt_valid,
	output logic [rv_pkg::lg_arch_regs-1:0] rslt_dst,
	output logic [rv_pkg::xlen-1:0] rslt_data,
	output logic rslt_unsupported,
	output logic redirect,
	output logic [rv_pkg::xlen-1:0] redirect_pc
);

	// only control transfers may steer fetch
	wire is_ctrl = ex_op inside {rv_pkg::BEQ, rv_pkg::BNE, rv_pkg::BLT, rv_pkg::BGE,
		rv_pkg::BLTU, rv_pkg::BGEU, rv_pkg::JAL, rv_pkg::JALR, rv_pkg::J,
		rv_pkg::JR, rv_pkg::RET};

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			rslt_valid <= 1'b0;
			wb_en <= 1'b0;
			redirect <= 1'b0;
			cycle_count <= '0;
			instret_count <= '0;
		end
		else
		begin
			rslt_valid <= ex_valid;
			wb_en <= ex_valid && ex_dst_valid;
			redirect <= ex_valid && is_ctrl && (ex_taken != ex_pred);
			cycle_count <= cycle_count + 64'd1;
			if (ex_valid)
				instret_count <= instret_count + 64'd1;
		end
		if (ex_valid)
		begin
			rslt_dst <= ex_dst_valid ? ex_dst : '0;
			rslt_data <= ex_value;
			rslt_unsupported <= ex_unsupported;
			redirect_pc <= ex_taken ? ex_target : ex_pc + 64'd4;
		end
	end

	// write port shares the retire registers
	assign wb_dst = rslt_dst;
	assign wb_data = rslt_data;

endmodule

// File: logic/rv_pkg.sv
package rv_pkg;

	parameter int xlen = 64;
	parameter int lg_arch_regs = 5;

	// major opcodes, insn[6:0]
	parameter logic [6:0] op_load = 7'h03;
	parameter logic [6:0] op_misc_mem = 7'h0f; // fence
	parameter logic [6:0] op_imm = 7'h13;
	parameter logic [6:0] op_auipc = 7'h17;
	parameter logic [6:0] op_imm32 = 7'h1b;
	parameter logic [6:0] op_store = 7'h23;
	parameter logic [6:0] op_reg = 7'h33;
	parameter logic [6:0] op_lui = 7'h37;
	parameter logic [6:0] op_branch = 7'h63;
	parameter logic [6:0] op_jalr = 7'h67;
	parameter logic [6:0] op_jal = 7'h6f;
	parameter logic [6:0] op_system = 7'h73;

	// csrrs sources
	parameter logic [11:0] csr_cycle = 12'hc00;
	parameter logic [11:0] csr_instret = 12'hc02;

	typedef enum logic [5:0] {
		// immediate forms
		ADDI, SLLI, SLTI, SLTIU, XORI,
		SRLI, SRAI, ORI, ANDI, ADDIW,
		// register forms
		ADDU, SUBU, SLL, SLT, SLTU,
		XOR, SRL, SRA, OR, AND,
		LUI, AUIPC,
		// control transfer
		BEQ, BNE, BLT, BGE, BLTU, BGEU,
		JAL, JALR, J, JR, RET,
		RDCYCLE, RDINSTRET,
		// decoded only, never executed
		LB, LH, LW, LD, LBU, LHU,
		SB, SH, SW, SD,
		MUL, MULH, MULHU,
		DIV, DIVU, REM, REMU,
		NOP,
		BREAK,
		MONITOR,
		II
	} uop_op_t;

endpackage

// File: tb/tb_rv_encode.svh
`ifndef TB_RV_ENCODE_SVH
`define TB_RV_ENCODE_SVH

logic [63:0] shadow [0:31]; // architectural view of x0..x31

function automatic logic [31:0] enc_i(input logic [6:0] opc, input logic [2:0] f3,
	input logic [4:0] rd, input logic [4:0] rs1, input logic [11:0] imm);
	return {imm, rs1, f3, rd, opc};
endfunction

function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [2:0] f3,
	input logic [4:0] rd, input logic [4:0] rs1, input logic [4:0] rs2);
	return {f7, rs2, rs1, f3, rd, rv_pkg::op_reg};
endfunction

function automatic logic [31:0] enc_s(input logic [2:0] f3, input logic [4:0] rs1,
	input logic [4:0] rs2, input logic [11:0] imm);
	return {imm[11:5], rs2, rs1, f3, imm[4:0], rv_pkg::op_store};
endfunction

function automatic logic [31:0] enc_b(input logic [2:0] f3, input logic [4:0] rs1,
	input logic [4:0] rs2, input logic [12:0] imm);
	return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], rv_pkg::op_branch};
endfunction

function automatic logic [31:0] enc_j(input logic [4:0] rd, input logic [20:0] imm);
	return {imm[20], imm[10:1], imm[11], imm[19:12], rd, rv_pkg::op_jal};
endfunction

function automatic logic [63:0] sext32(input logic [31:0] v);
	return {{32{v[31]}}, v};
endfunction

// RV64I integer semantics, alt selects sub and sra
function automatic logic [63:0] alu_ref(input logic [2:0] f3, input logic alt,
	input logic [63:0] a, input logic [63:0] b);
	case (f3)
		3'd0: return alt ? a - b : a + b;
		3'd1: return a << b[5:0];
		3'd2: return {63'd0, $signed(a) < $signed(b)};
		3'd3: return {63'd0, a < b};
		3'd4: return a ^ b;
		3'd5: return alt ? 64'($signed(a) >>> b[5:0]) : a >> b[5:0];
		3'd6: return a | b;
		default: return a & b;
	endcase
endfunction

function automatic logic br_ref(input logic [2:0] f3, input logic [63:0] a,
	input logic [63:0] b);
	case (f3)
		3'd0: return a == b;
		3'd1: return a != b;
		3'd4: return $signed(a) < $signed(b);
		3'd5: return $signed(a) >= $signed(b);
		3'd6: return a < b;
		default: return a >= b;
	endcase
endfunction

`endif

// File: tb/tb_int_core.sv
module tb_int_core;

	`include "tb_rv_encode.svh"

	localparam int total_insns = 180;
	localparam int cycle_limit = 40 * total_insns;

	logic clk = 1'b0;
	logic rst, insn_valid, insn_pred, mode64;
	logic [31:0] insn;
	logic [63:0] pc;
	logic rslt_valid, rslt_unsupported, redirect;
	logic [4:0] rslt_dst;
	logic [63:0] rslt_data, redirect_pc;

	int cycles = 0;
	int neg_cnt = 0;
	int n_issued = 0;
	logic [63:0] cur_pc = 64'h1000;
	logic m64 = 1'b1;
	int q_due[$];
	logic [4:0] q_dst[$];
	logic [63:0] q_data[$], q_rpc[$], cap_q[$];
	logic q_unsup[$], q_redir[$], q_chk[$], q_cap[$];

	int_core UUT(
		.clk(clk), .rst(rst), .insn_valid(insn_valid), .insn(insn), .pc(pc),
		.insn_pred(insn_pred), .mode64(mode64),
		.rslt_valid(rslt_valid), .rslt_dst(rslt_dst), .rslt_data(rslt_data),
		.rslt_unsupported(rslt_unsupported), .redirect(redirect),
		.redirect_pc(redirect_pc));

	always #4 clk = ~clk;

	always @(posedge clk)
	begin
		cycles++;
		if (cycles > cycle_limit)
		begin
			$display("timeout: results stopped arriving after %0d cycles", cycles);
			$display("TEST RESULT: FAIL");
			$fatal(1, "simulation ran past its cycle limit");
		end
	end

	task automatic check(input string what, input logic [63:0] got, input logic [63:0] exp);
		if (got !== exp)
		begin
			$display("FAIL at %0t: %s got %h expected %h", $time, what, got, exp);
			$display("TEST RESULT: FAIL");
			$fatal(1, "mismatch on %s", what);
		end
	endtask

	// outputs are stable at the falling edge
	always @(negedge clk)
	begin
		neg_cnt++;
		if (!rst)
		begin
			if (q_due.size() > 0 && q_due[0] == neg_cnt)
			begin
				check("rslt_valid", rslt_valid, 1);
				check("rslt_dst", rslt_dst, q_dst[0]);
				check("rslt_unsupported", rslt_unsupported, q_unsup[0]);
				check("redirect", redirect, q_redir[0]);
				check("redirect_pc", redirect_pc, q_rpc[0]);
				if (q_chk[0])
					check("rslt_data", rslt_data, q_data[0]);
				if (q_cap[0])
					cap_q.push_back(rslt_data);
				void'(q_due.pop_front());
				void'(q_dst.pop_front());
				void'(q_data.pop_front());
				void'(q_unsup.pop_front());
				void'(q_redir.pop_front());
				void'(q_rpc.pop_front());
				void'(q_chk.pop_front());
				void'(q_cap.pop_front());
			end
			else
				check("stray rslt_valid", rslt_valid, 0);
		end
	end

	task automatic issue(input logic [31:0] w, input logic pred, input logic [4:0] edst,
		input logic [63:0] edata, input logic eunsup, input logic eredir,
		input logic [63:0] erpc, input logic cap);
		@(posedge clk);
		insn_valid <= 1'b1;
		insn <= w;
		pc <= cur_pc;
		insn_pred <= pred;
		mode64 <= m64;
		q_due.push_back(neg_cnt + 3); // sampled next edge, retires two edges later
		q_dst.push_back(edst);
		q_data.push_back(edata);
		q_unsup.push_back(eunsup);
		q_redir.push_back(eredir);
		q_rpc.push_back(erpc);
		q_chk.push_back(edst != 0 && !cap);
		q_cap.push_back(cap);
		cur_pc += 4;
		n_issued++;
	endtask

	task automatic idle(input int n);
		repeat (n)
		begin
			@(posedge clk);
			insn_valid <= 1'b0;
		end
	endtask

	task automatic drain();
		while (q_due.size() > 0)
		begin
			@(posedge clk);
			insn_valid <= 1'b0;
		end
	endtask

	task automatic alu_imm(input logic [2:0] f3, input logic [4:0] rd, input logic [4:0] rs1,
		input logic [11:0] imm);
		logic [63:0] r;
		r = alu_ref(f3, f3 == 3'd5 && imm[10], shadow[rs1], {{52{imm[11]}}, imm});
		if (rd != 0)
			shadow[rd] = r;
		issue(enc_i(rv_pkg::op_imm, f3, rd, rs1, imm), 1'b0, rd, r, 1'b0, 1'b0, cur_pc + 4, 1'b0);
	endtask

	task automatic alu_reg(input logic [6:0] f7, input logic [2:0] f3, input logic [4:0] rd,
		input logic [4:0] rs1, input logic [4:0] rs2);
		logic [63:0] r;
		r = alu_ref(f3, f7[5], shadow[rs1], shadow[rs2]);
		if (rd != 0)
			shadow[rd] = r;
		issue(enc_r(f7, f3, rd, rs1, rs2), 1'b0, rd, r, 1'b0, 1'b0, cur_pc + 4, 1'b0);
	endtask

	task automatic load_reg(input logic [4:0] rd, input logic [31:0] v);
		logic [31:0] hi;
		hi = (v + 32'h800) & 32'hffff_f000;
		shadow[rd] = sext32(hi);
		issue({hi[31:12], rd, rv_pkg::op_lui}, 1'b0, rd, shadow[rd], 1'b0, 1'b0, cur_pc + 4, 1'b0);
		alu_imm(3'd0, rd, rd, v[11:0]);
	endtask

	task automatic addiw(input logic [4:0] rd, input logic [4:0] rs1, input logic [11:0] imm);
		logic [31:0] s;
		s = shadow[rs1][31:0] + {{20{imm[11]}}, imm};
		shadow[rd] = sext32(s);
		issue(enc_i(rv_pkg::op_imm32, 3'd0, rd, rs1, imm), 1'b0, rd, shadow[rd], 1'b0, 1'b0,
			cur_pc + 4, 1'b0);
	endtask

	task automatic auipc(input logic [4:0] rd, input logic [19:0] imm);
		logic [63:0] s;
		s = cur_pc + sext32({imm, 12'd0});
		shadow[rd] = m64 ? s : sext32(s[31:0]); // low mode keeps a 32-bit address space
		issue({imm, rd, rv_pkg::op_auipc}, 1'b0, rd, shadow[rd], 1'b0, 1'b0, cur_pc + 4, 1'b0);
	endtask

	task automatic branch(input logic [2:0] f3, input logic [4:0] rs1, input logic [4:0] rs2,
		input logic [12:0] imm, input logic pred);
		logic taken;
		logic [63:0] tgt;
		taken = br_ref(f3, shadow[rs1], shadow[rs2]);
		tgt = cur_pc + {{51{imm[12]}}, imm};
		issue(enc_b(f3, rs1, rs2, imm), pred, 5'd0, 64'd0, 1'b0, taken != pred,
			taken ? tgt : cur_pc + 4, 1'b0);
	endtask

	task automatic jal(input logic [4:0] rd, input logic [20:0] imm);
		logic [63:0] tgt;
		tgt = cur_pc + {{43{imm[20]}}, imm};
		if (rd != 0)
			shadow[rd] = cur_pc + 4;
		issue(enc_j(rd, imm), 1'b1, rd, cur_pc + 4, 1'b0, 1'b0, tgt, 1'b0);
	endtask

	// no target predictor, so only a fall-through target is predicted right
	task automatic jalr(input logic [4:0] rd, input logic [4:0] rs1, input logic [11:0] imm);
		logic [63:0] tgt;
		tgt = (shadow[rs1] + {{52{imm[11]}}, imm}) & ~64'd1;
		if (rd != 0)
			shadow[rd] = cur_pc + 4;
		issue(enc_i(rv_pkg::op_jalr, 3'd0, rd, rs1, imm), 1'b1, rd, cur_pc + 4, 1'b0,
			tgt != cur_pc + 4, tgt, 1'b0);
	endtask

	task automatic imm_alu_test();
		logic [5:0] sh;
		logic [2:0] f3;
		for (int r = 1; r <= 4; r++)
			load_reg(5'(r), $urandom);
		for (int i = 0; i < 16; i++)
		begin
			f3 = 3'(i);
			sh = 6'($urandom);
			if (f3 == 3'd1)
				alu_imm(f3, 5'(1 + $urandom % 4), 5'(1 + $urandom % 4), {6'h00, sh});
			else if (f3 == 3'd5)
				alu_imm(f3, 5'(1 + $urandom % 4), 5'(1 + $urandom % 4), {i[3] ? 6'h10 : 6'h00, sh});
			else
				alu_imm(f3, 5'(1 + $urandom % 4), 5'(1 + $urandom % 4), 12'($urandom));
		end
		addiw(5'd2, 5'd1, 12'($urandom));
		m64 = 1'b0;
		addiw(5'd3, 5'd4, 12'($urandom));
		auipc(5'd4, 20'h7ffff);
		m64 = 1'b1;
		auipc(5'd1, 20'h7ffff);
		alu_imm(3'd0, 5'd0, 5'd1, 12'h123); // discarded write to x0
		alu_reg(7'h00, 3'd0, 5'd4, 5'd0, 5'd1);
		drain();
	endtask

	task automatic reg_chain_test();
		logic [2:0] f3;
		logic [4:0] prev, prev2, rd;
		prev = 5'd1;
		prev2 = 5'd2;
		for (int i = 0; i < 14; i++)
		begin
			f3 = 3'($urandom);
			rd = 5'(5 + i % 5);
			alu_reg((f3 == 3'd0 || f3 == 3'd5) && $urandom % 2 ? 7'h20 : 7'h00, f3, rd, prev, prev2);
			prev2 = prev;
			prev = rd;
		end
		drain();
	endtask

	task automatic branch_test();
		logic [2:0] conds [6] = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
		for (int c = 0; c < 6; c++)
		begin
			for (int k = 0; k < 4; k++)
			begin
				load_reg(5'd10, $urandom);
				if ($urandom % 3 == 0)
					alu_imm(3'd0, 5'd11, 5'd10, 12'd0);
				else
					load_reg(5'd11, $urandom);
				branch(conds[c], 5'd10, 5'd11, {13'($urandom) & 13'h1ffe}, 1'($urandom));
			end
		end
		drain();
	endtask

	task automatic jump_test();
		jal(5'd1, 21'($urandom) & 21'h1ffffe);
		jal(5'd0, 21'h000040);
		load_reg(5'd12, 32'(cur_pc + 12)); // jalr two slots later falls through
		jalr(5'd2, 5'd12, 12'd0);
		jalr(5'd3, 5'd12, 12'h101);
		jalr(5'd0, 5'd12, 12'h020);
		jalr(5'd0, 5'd1, 12'd0);
		alu_reg(7'h00, 3'd0, 5'd4, 5'd2, 5'd3);
		drain();
	endtask

	task automatic unsupported_test();
		load_reg(5'd5, $urandom);
		issue(enc_i(rv_pkg::op_load, 3'd3, 5'd5, 5'd1, 12'd0), 1'b0, 5'd0, 64'd0, 1'b1, 1'b0,
			cur_pc + 4, 1'b0);
		issue(enc_s(3'd3, 5'd1, 5'd5, 12'd8), 1'b0, 5'd0, 64'd0, 1'b1, 1'b0, cur_pc + 4, 1'b0);
		issue(enc_r(7'h01, 3'd0, 5'd5, 5'd1, 5'd2), 1'b0, 5'd0, 64'd0, 1'b1, 1'b0,
			cur_pc + 4, 1'b0);
		issue(32'h0ff0_000f, 1'b0, 5'd0, 64'd0, 1'b1, 1'b0, cur_pc + 4, 1'b0);
		alu_imm(3'd6, 5'd5, 5'd5, 12'd0); // x5 must be unchanged
		drain();
	endtask

	task automatic counter_test();
		int k;
		k = 3;
		for (int i = 0; i < 2; i++)
		begin
			shadow[13] = n_issued;
			issue(enc_i(rv_pkg::op_system, 3'd2, 5'd13, 5'd0, rv_pkg::csr_instret), 1'b0, 5'd13,
				n_issued, 1'b0, 1'b0, cur_pc + 4, 1'b0);
		end
		issue(enc_i(rv_pkg::op_system, 3'd2, 5'd14, 5'd0, rv_pkg::csr_cycle), 1'b0, 5'd14,
			64'd0, 1'b0, 1'b0, cur_pc + 4, 1'b1);
		idle(k);
		issue(enc_i(rv_pkg::op_system, 3'd2, 5'd15, 5'd0, rv_pkg::csr_cycle), 1'b0, 5'd15,
			64'd0, 1'b0, 1'b0, cur_pc + 4, 1'b1);
		drain();
		check("rdcycle distance", cap_q[1] - cap_q[0], 64'(k + 1));
		shadow[14] = cap_q[0];
		shadow[15] = cap_q[1];
	endtask

	initial
	begin
		rst = 1'b1;
		insn_valid = 1'b0;
		insn = 32'd0;
		pc = 64'd0;
		insn_pred = 1'b0;
		mode64 = 1'b1;
		for (int i = 0; i < 32; i++)
			shadow[i] = 64'd0;
		void'($urandom(18));
		repeat (8) @(posedge clk);
		rst <= 1'b0;
		imm_alu_test();
		reg_chain_test();
		branch_test();
		jump_test();
		unsupported_test();
		counter_test();
		idle(2);
		$display("TEST RESULT: PASS");
		$finish;
	end

endmodule
